// File: verilog.f
+incdir+include
+incdir+tests
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/controlFsm.sv
hw/datapath.sv
hw/memArbiter.sv
hw/wordMemory.sv
hw/cpuTop.sv
tests/cpuTb.sv

// File: run.sh
#!/bin/sh
# Builds the simulation with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f verilog.f --top-module cpuTb -o cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: tests/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// one word per line, loaded from word address 0 upward
localparam int PROGRAM_LEN = 22;

localparam logic [31:0] PROGRAM_WORDS [PROGRAM_LEN] = '{
    32'h20010005, // addi r1, r0, 5
    32'h2002FFFC, // addi r2, r0, -4
    32'h00221820, // add  r3, r1, r2
    32'h00222022, // sub  r4, r1, r2
    32'h00222824, // and  r5, r1, r2
    32'h00223025, // or   r6, r1, r2
    32'h0041382A, // slt  r7, r2, r1
    32'h0022402A, // slt  r8, r1, r2
    32'h20200007, // addi r0, r1, 7
    32'h00044820, // add  r9, r0, r4
    32'hAC040320, // sw   r4, 800(r0)
    32'h8C0A0320, // lw   r10, 800(r0)
    32'h10210001, // beq  r1, r1, +1 taken
    32'h200B0063, // addi r11, r0, 99 skipped
    32'h10220005, // beq  r1, r2, +5 not taken
    32'h14220001, // bne  r1, r2, +1 taken
    32'h200B004D, // addi r11, r0, 77 skipped
    32'h14210003, // bne  r1, r1, +3 not taken
    32'h08000014, // j    0x50
    32'h200B0037, // addi r11, r0, 55 skipped
    32'h200C0001, // addi r12, r0, 1
    32'h08000015  // j    0x54 (spin)
};

// columns: pc, nextPc, regWe, regAddr, regData, memWe, memAddr (word)
// regAddr and regData only count where regWe is set
localparam int RETIRE_COUNT = 19;

localparam ctrlPkg::retire_t EXPECTED [RETIRE_COUNT] = '{
    '{32'h00, 32'h04, 1'b1, 5'd1,  32'h00000005, 1'b0, 8'd0},
    '{32'h04, 32'h08, 1'b1, 5'd2,  32'hFFFFFFFC, 1'b0, 8'd0},
    '{32'h08, 32'h0C, 1'b1, 5'd3,  32'h00000001, 1'b0, 8'd0},
    '{32'h0C, 32'h10, 1'b1, 5'd4,  32'h00000009, 1'b0, 8'd0},
    '{32'h10, 32'h14, 1'b1, 5'd5,  32'h00000004, 1'b0, 8'd0},
    '{32'h14, 32'h18, 1'b1, 5'd6,  32'hFFFFFFFD, 1'b0, 8'd0},
    '{32'h18, 32'h1C, 1'b1, 5'd7,  32'h00000001, 1'b0, 8'd0},
    '{32'h1C, 32'h20, 1'b1, 5'd8,  32'h00000000, 1'b0, 8'd0},
    '{32'h20, 32'h24, 1'b1, 5'd0,  32'h0000000C, 1'b0, 8'd0},
    '{32'h24, 32'h28, 1'b1, 5'd9,  32'h00000009, 1'b0, 8'd0},
    '{32'h28, 32'h2C, 1'b0, 5'd0,  32'h00000000, 1'b1, 8'd200},
    '{32'h2C, 32'h30, 1'b1, 5'd10, 32'h00000009, 1'b0, 8'd0},
    '{32'h30, 32'h38, 1'b0, 5'd0,  32'h00000000, 1'b0, 8'd0},
    '{32'h38, 32'h3C, 1'b0, 5'd0,  32'h00000000, 1'b0, 8'd0},
    '{32'h3C, 32'h44, 1'b0, 5'd0,  32'h00000000, 1'b0, 8'd0},
    '{32'h44, 32'h48, 1'b0, 5'd0,  32'h00000000, 1'b0, 8'd0},
    '{32'h48, 32'h50, 1'b0, 5'd0,  32'h00000000, 1'b0, 8'd0},
    '{32'h50, 32'h54, 1'b1, 5'd12, 32'h00000001, 1'b0, 8'd0},
    '{32'h54, 32'h54, 1'b0, 5'd0,  32'h00000000, 1'b0, 8'd0}
};

`endif

// File: tests/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb;

    localparam int LOAD_TIMEOUT   = 20;
    localparam int RETIRE_TIMEOUT = 40;

    `include "programTable.svh"

    logic             clk = 1'b0;
    logic             rstN = 1'b0;
    logic             run = 1'b0;
    logic             loadValid = 1'b0;
    ctrlPkg::memReq_t loadReq = '0;
    logic             loadReady;
    logic             retireValid;
    ctrlPkg::retire_t retire;
    logic [31:0]      rngState;

    cpuTop UUT (
        .clk         (clk),
        .rstN        (rstN),
        .run         (run),
        .loadValid   (loadValid),
        .loadReq     (loadReq),
        .loadReady   (loadReady),
        .retireValid (retireValid),
        .retire      (retire)
    );

    initial
    begin
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t %s is %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // holds the request until the port takes it
    task automatic loadWord(input int addr, input logic [31:0] word);
        int waited;
        waited = 0;
        loadValid     = 1'b1;
        loadReq.addr  = `MEM_AW'(addr);
        loadReq.data  = word;
        loadReq.write = 1'b1;
        while (!loadReady)
        begin
            @(negedge clk);
            waited++;
            if (waited > LOAD_TIMEOUT)
            begin
                $display("loader port was not ready for %0d cycles at word %0d", waited, addr);
                abortRun();
            end
        end
        @(negedge clk); // accepted on the rising edge in between
        loadValid = 1'b0;
        loadReq   = '0;
    endtask

    task automatic waitRetire(input int index);
        int waited;
        waited = 0;
        while (!retireValid)
        begin
            @(negedge clk);
            waited++;
            if (waited > RETIRE_TIMEOUT)
            begin
                $display("no instruction retired within %0d cycles, waiting for record %0d",
                         waited, index);
                abortRun();
            end
        end
    endtask

    task automatic compareRecord(input int index);
        ctrlPkg::retire_t want;
        want = EXPECTED[index];
        checkValue(retire.pc, want.pc, $sformatf("record %0d pc", index));
        checkValue(retire.nextPc, want.nextPc, $sformatf("record %0d nextPc", index));
        checkValue(32'(retire.regWe), 32'(want.regWe), $sformatf("record %0d regWe", index));
        if (want.regWe)
        begin
            checkValue(32'(retire.regAddr), 32'(want.regAddr),
                       $sformatf("record %0d regAddr", index));
            checkValue(retire.regData, want.regData, $sformatf("record %0d regData", index));
        end
        checkValue(32'(retire.memWe), 32'(want.memWe), $sformatf("record %0d memWe", index));
        checkValue(32'(retire.memAddr), 32'(want.memAddr),
                   $sformatf("record %0d memAddr", index));
    endtask

    // nothing may retire while the core is held idle
    always @(negedge clk)
    begin
        if (!run)
            checkValue(32'(retireValid), 32'd0, "retireValid before run");
    end

    initial
    begin
        rngState = 32'd48;

        repeat (3) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue(32'(loadReady), 32'd1, "loadReady after reset");

        for (int i = 0; i < PROGRAM_LEN; i++)
        begin
            loadWord(i, PROGRAM_WORDS[i]);
            rngState = nextRandom(rngState);
            repeat (rngState[1:0]) @(negedge clk); // gap of 0 to 3 cycles
        end

        run = 1'b1;
        for (int i = 0; i < RETIRE_COUNT; i++)
        begin
            waitRetire(i);
            compareRecord(i);
            @(negedge clk);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             run,
    input  logic             loadValid,
    input  ctrlPkg::memReq_t loadReq,
    output logic             loadReady,
    output logic             retireValid,
    output ctrlPkg::retire_t retire
);

    ctrlPkg::ctrlWord_t ctrl;
    isaPkg::instr_u     instr;
    logic               zero;
    logic               fetchValid;
    logic               fetchReady;
    logic               fetchRespValid;
    logic               dataValid;
    logic               dataReady;
    logic               dataRespValid;
    ctrlPkg::word_t     fetchRdata;
    ctrlPkg::word_t     dataRdata;
    ctrlPkg::memReq_t   fetchReq;
    ctrlPkg::memReq_t   dataReq;
    logic               memValid;
    ctrlPkg::memReq_t   memReq;
    logic               memRespValid;
    ctrlPkg::word_t     memRdata;

    controlFsm fsm (
        .clk            (clk),
        .rstN           (rstN),
        .run            (run),
        .instr          (instr),
        .zero           (zero),
        .fetchReady     (fetchReady),
        .fetchRespValid (fetchRespValid),
        .dataReady      (dataReady),
        .dataRespValid  (dataRespValid),
        .ctrl           (ctrl),
        .fetchValid     (fetchValid),
        .dataValid      (dataValid)
    );

    datapath dp (
        .clk            (clk),
        .rstN           (rstN),
        .ctrl           (ctrl),
        .fetchRdata     (fetchRdata),
        .dataRdata      (dataRdata),
        .fetchRespValid (fetchRespValid),
        .dataRespValid  (dataRespValid),
        .instr          (instr),
        .zero           (zero),
        .fetchReq       (fetchReq),
        .dataReq        (dataReq),
        .retireValid    (retireValid),
        .retire         (retire)
    );

    memArbiter arbiter (
        .clk            (clk),
        .rstN           (rstN),
        .loadValid      (loadValid),
        .fetchValid     (fetchValid),
        .dataValid      (dataValid),
        .loadReq        (loadReq),
        .fetchReq       (fetchReq),
        .dataReq        (dataReq),
        .memRespValid   (memRespValid),
        .memRdata       (memRdata),
        .loadReady      (loadReady),
        .fetchReady     (fetchReady),
        .dataReady      (dataReady),
        .memValid       (memValid),
        .memReq         (memReq),
        .fetchRespValid (fetchRespValid),
        .dataRespValid  (dataRespValid),
        .fetchRdata     (fetchRdata),
        .dataRdata      (dataRdata)
    );

    wordMemory memory (
        .clk          (clk),
        .memValid     (memValid),
        .memReq       (memReq),
        .memRespValid (memRespValid),
        .memRdata     (memRdata)
    );

endmodule

// File: hw/wordMemory.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module wordMemory (
    input  logic             clk,
    input  logic             memValid,
    input  ctrlPkg::memReq_t memReq,
    output logic             memRespValid,
    output ctrlPkg::word_t   memRdata
);

    ctrlPkg::word_t mem [`MEM_WORDS];

    always_ff @(posedge clk)
    begin
        memRespValid <= memValid; // writes answer too
        if (memValid)
        begin
            if (memReq.write)
                mem[memReq.addr] <= memReq.data;
            memRdata <= mem[memReq.addr]; // old word on a write
        end
    end

endmodule

// File: hw/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic             clk,
    input  logic             rstN,
    input  logic             loadValid,
    input  logic             fetchValid,
    input  logic             dataValid,
    input  ctrlPkg::memReq_t loadReq,
    input  ctrlPkg::memReq_t fetchReq,
    input  ctrlPkg::memReq_t dataReq,
    input  logic             memRespValid,
    input  ctrlPkg::word_t   memRdata,
    output logic             loadReady,
    output logic             fetchReady,
    output logic             dataReady,
    output logic             memValid,
    output ctrlPkg::memReq_t memReq,
    output logic             fetchRespValid,
    output logic             dataRespValid,
    output ctrlPkg::word_t   fetchRdata,
    output ctrlPkg::word_t   dataRdata
);

    logic armed; // keeps every port stalled straight out of reset
    logic busy;
    logic ownFetch;
    logic ownData;
    logic loadGrant;
    logic dataGrant;
    logic fetchGrant;

    // loader over data over fetch
    assign loadReady  = armed && !busy;
    assign dataReady  = loadReady && !loadValid;
    assign fetchReady = dataReady && !dataValid;

    assign loadGrant  = loadValid && loadReady;
    assign dataGrant  = dataValid && dataReady;
    assign fetchGrant = fetchValid && fetchReady;
    assign memValid   = loadGrant || dataGrant || fetchGrant;

    always_comb
    begin
        if (loadGrant)
            memReq = loadReq;
        else if (dataGrant)
            memReq = dataReq;
        else
            memReq = fetchReq;
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            armed    <= 1'b0;
            busy     <= 1'b0;
            ownFetch <= 1'b0;
            ownData  <= 1'b0;
        end
        else
        begin
            armed <= 1'b1;
            if (memValid)
            begin
                busy     <= 1'b1;
                ownFetch <= fetchGrant;
                ownData  <= dataGrant;
            end
            else if (memRespValid)
                busy <= 1'b0;
        end
    end

    // loader responses go nowhere
    assign fetchRespValid = memRespValid && ownFetch;
    assign dataRespValid  = memRespValid && ownData;
    assign fetchRdata     = memRdata;
    assign dataRdata      = memRdata;

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapath (
    input  logic               clk,
    input  logic               rstN,
    input  ctrlPkg::ctrlWord_t ctrl,
    input  ctrlPkg::word_t     fetchRdata,
    input  ctrlPkg::word_t     dataRdata,
    input  logic               fetchRespValid,
    input  logic               dataRespValid,
    output isaPkg::instr_u     instr,
    output logic               zero,
    output ctrlPkg::memReq_t   fetchReq,
    output ctrlPkg::memReq_t   dataReq,
    output logic               retireValid,
    output ctrlPkg::retire_t   retire
);

    ctrlPkg::word_t               pc;
    ctrlPkg::word_t               curPc;
    isaPkg::instr_u               ir;
    ctrlPkg::word_t               regs [`REG_COUNT];
    ctrlPkg::word_t               a;
    ctrlPkg::word_t               b;
    ctrlPkg::word_t               aluOut;
    ctrlPkg::word_t               mdr;
    ctrlPkg::word_t               immExt;
    ctrlPkg::word_t               jumpTarget;
    ctrlPkg::word_t               srcA;
    ctrlPkg::word_t               srcB;
    ctrlPkg::word_t               aluResult;
    ctrlPkg::word_t               pcNext;
    ctrlPkg::word_t               wData;
    ctrlPkg::word_t               wbData;
    logic [ctrlPkg::REG_AW-1:0]   wAddr;
    logic [ctrlPkg::REG_AW-1:0]   wbAddr;
    logic                         wbWe;
    logic                         pcLoad;
    logic                         fetchDone;
    logic                         isStore;

    assign instr     = ir;
    assign fetchDone = ctrl.irWrite && fetchRespValid;
    assign isStore   = (ir.i.op == isaPkg::OP_SW);

    assign immExt     = {{(`XLEN-16){ir.i.imm[15]}}, ir.i.imm};
    assign jumpTarget = {pc[`XLEN-1:28], ir.j.target, 2'b00}; // upper bits of pc + 4

    assign srcA = ctrl.aluSrcA ? a : pc;

    always_comb
    begin
        case (ctrl.aluSrcB)
            2'd0:    srcB = b;
            2'd1:    srcB = `XLEN'd4;
            2'd2:    srcB = immExt;
            default: srcB = {immExt[`XLEN-3:0], 2'b00};
        endcase
    end

    always_comb
    begin
        case (ctrl.aluOp)
            ctrlPkg::ALU_SUB: aluResult = srcA - srcB;
            ctrlPkg::ALU_AND: aluResult = srcA & srcB;
            ctrlPkg::ALU_OR:  aluResult = srcA | srcB;
            ctrlPkg::ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default:          aluResult = srcA + srcB;
        endcase
    end

    assign zero = (aluResult == '0);

    // bne takes the branch on a nonzero difference
    assign pcLoad = ctrl.pcWrite || (ctrl.pcWriteCond && (zero != ctrl.branchNotEqual));

    always_comb
    begin
        case (ctrl.pcSource)
            2'd1:    pcNext = aluOut;
            2'd2:    pcNext = jumpTarget;
            default: pcNext = aluResult;
        endcase
    end

    assign wAddr = ctrl.regDestRd ? ir.r.rd : ir.r.rt;
    assign wData = ctrl.memToReg ? mdr : aluOut;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc     <= '0;
            curPc  <= '0;
            ir.raw <= '0;
            wbWe   <= 1'b0;
        end
        else
        begin
            if (pcLoad)
                pc <= pcNext;
            if (fetchDone)
            begin
                ir.raw <= fetchRdata;
                curPc  <= pc;
                wbWe   <= 1'b0;
            end
            if (ctrl.regWrite)
                wbWe <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int k = 0; k < `REG_COUNT; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (ctrl.regWrite && wAddr != '0)
        begin
            regs[wAddr] <= wData; // r0 stays zero
        end
    end

    always_ff @(posedge clk)
    begin
        a <= regs[ir.r.rs];
        b <= regs[ir.r.rt];
        if (ctrl.aluOutLoad)
            aluOut <= aluResult;
        if (dataRespValid && ctrl.memToReg)
            mdr <= dataRdata;
        if (ctrl.regWrite)
        begin
            wbAddr <= wAddr;
            wbData <= wData;
        end
    end

    assign fetchReq.addr  = pc[`MEM_AW+1:2];
    assign fetchReq.data  = '0;
    assign fetchReq.write = 1'b0;

    assign dataReq.addr  = aluOut[`MEM_AW+1:2];
    assign dataReq.data  = b;
    assign dataReq.write = isStore;

    assign retireValid     = ctrl.retire;
    assign retire.pc       = curPc;
    assign retire.nextPc   = pc;
    assign retire.regWe    = wbWe;
    assign retire.regAddr  = wbAddr;
    assign retire.regData  = wbData;
    assign retire.memWe    = isStore;
    assign retire.memAddr  = isStore ? dataReq.addr : '0;

endmodule

// File: hw/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  isaPkg::instr_u     instr,
    input  logic               zero,
    input  logic               fetchReady,
    input  logic               fetchRespValid,
    input  logic               dataReady,
    input  logic               dataRespValid,
    output ctrlPkg::ctrlWord_t ctrl,
    output logic               fetchValid,
    output logic               dataValid
);

    ctrlPkg::state_e  state;
    ctrlPkg::state_e  nextState;
    ctrlPkg::aluOp_e  functOp;
    isaPkg::opcode_e  op;

    assign op = instr.r.op;

    assign fetchValid = (state == ctrlPkg::FETCH);
    assign dataValid  = (state == ctrlPkg::MEM_REQ);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            state <= ctrlPkg::IDLE;
        else
            state <= nextState;
    end

    always_comb
    begin
        case (instr.r.funct)
            isaPkg::FN_SUB: functOp = ctrlPkg::ALU_SUB;
            isaPkg::FN_AND: functOp = ctrlPkg::ALU_AND;
            isaPkg::FN_OR:  functOp = ctrlPkg::ALU_OR;
            isaPkg::FN_SLT: functOp = ctrlPkg::ALU_SLT;
            default:        functOp = ctrlPkg::ALU_ADD;
        endcase
    end

    always_comb
    begin
        nextState = state;
        case (state)
            ctrlPkg::IDLE:
                if (run)
                    nextState = ctrlPkg::FETCH;
            ctrlPkg::FETCH:
                if (fetchReady)
                    nextState = ctrlPkg::FETCH_WAIT;
            ctrlPkg::FETCH_WAIT:
                if (fetchRespValid)
                    nextState = ctrlPkg::DECODE;
            ctrlPkg::DECODE:
            begin
                case (op)
                    isaPkg::OP_RTYPE, isaPkg::OP_ADDI, isaPkg::OP_LW, isaPkg::OP_SW,
                    isaPkg::OP_BEQ, isaPkg::OP_BNE, isaPkg::OP_J:
                        nextState = ctrlPkg::EXECUTE;
                    default:
                        nextState = ctrlPkg::RETIRE; // unknown opcode retires as a nop
                endcase
            end
            ctrlPkg::EXECUTE:
            begin
                case (op)
                    isaPkg::OP_LW, isaPkg::OP_SW:
                        nextState = ctrlPkg::MEM_REQ;
                    isaPkg::OP_BEQ, isaPkg::OP_BNE, isaPkg::OP_J:
                        nextState = ctrlPkg::RETIRE;
                    default:
                        nextState = ctrlPkg::WRITEBACK;
                endcase
            end
            ctrlPkg::MEM_REQ:
                if (dataReady)
                    nextState = ctrlPkg::MEM_WAIT;
            ctrlPkg::MEM_WAIT:
                if (dataRespValid)
                    nextState = ctrlPkg::WRITEBACK; // sw passes through too
            ctrlPkg::WRITEBACK:
                nextState = ctrlPkg::RETIRE;
            default:
                nextState = ctrlPkg::FETCH;
        endcase
    end

    always_comb
    begin
        ctrl = '0;
        ctrl.aluOp = ctrlPkg::ALU_ADD;
        case (state)
            ctrlPkg::FETCH_WAIT:
            begin
                ctrl.irWrite = 1'b1;
                ctrl.pcWrite = fetchRespValid; // pc + 4 with the arriving word
                ctrl.aluSrcB = 2'd1;
            end
            ctrlPkg::DECODE:
            begin
                ctrl.aluSrcB    = 2'd3; // branch target into aluOut
                ctrl.aluOutLoad = 1'b1;
            end
            ctrlPkg::EXECUTE:
            begin
                ctrl.aluSrcA = 1'b1;
                case (op)
                    isaPkg::OP_RTYPE:
                    begin
                        ctrl.aluOp      = functOp;
                        ctrl.aluOutLoad = 1'b1;
                    end
                    isaPkg::OP_ADDI, isaPkg::OP_LW, isaPkg::OP_SW:
                    begin
                        ctrl.aluSrcB    = 2'd2;
                        ctrl.aluOutLoad = 1'b1;
                    end
                    isaPkg::OP_BEQ, isaPkg::OP_BNE:
                    begin
                        ctrl.aluOp          = ctrlPkg::ALU_SUB;
                        ctrl.pcWriteCond    = 1'b1;
                        ctrl.branchNotEqual = (op == isaPkg::OP_BNE);
                        ctrl.pcSource       = 2'd1;
                    end
                    isaPkg::OP_J:
                    begin
                        ctrl.pcWrite  = 1'b1;
                        ctrl.pcSource = 2'd2;
                    end
                    default:
                        ctrl.aluOutLoad = 1'b0;
                endcase
            end
            ctrlPkg::MEM_WAIT:
                ctrl.memToReg = (op == isaPkg::OP_LW); // latch load data
            ctrlPkg::WRITEBACK:
            begin
                ctrl.regWrite  = (op != isaPkg::OP_SW);
                ctrl.regDestRd = (op == isaPkg::OP_RTYPE);
                ctrl.memToReg  = (op == isaPkg::OP_LW);
            end
            ctrlPkg::RETIRE:
                ctrl.retire = 1'b1;
            default:
                ctrl.retire = 1'b0;
        endcase
    end

endmodule

// File: hw/ctrlPkg.sv
`include "cpu_defs.svh"

package ctrlPkg;

    localparam int REG_AW = $clog2(`REG_COUNT);

    typedef logic [`XLEN-1:0] word_t;

    typedef enum logic [3:0]
    {
        IDLE,
        FETCH,
        FETCH_WAIT,
        DECODE,
        EXECUTE,
        MEM_REQ,
        MEM_WAIT,
        WRITEBACK,
        RETIRE
    } state_e;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    typedef struct packed
    {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       branchNotEqual;
        logic       irWrite;
        logic       regWrite;
        logic       regDestRd;   // rd for R-type, rt otherwise
        logic       memToReg;
        logic       aluSrcA;     // 0 pc, 1 reg A
        logic [1:0] aluSrcB;     // 0 reg B, 1 four, 2 imm, 3 imm << 2
        aluOp_e     aluOp;
        logic [1:0] pcSource;    // 0 alu, 1 aluOut, 2 jump
        logic       aluOutLoad;
        logic       retire;
    } ctrlWord_t;

    typedef struct packed
    {
        logic [`MEM_AW-1:0] addr; // word address
        word_t              data;
        logic               write;
    } memReq_t;

    typedef struct packed
    {
        word_t              pc;
        word_t              nextPc;
        logic               regWe;
        logic [REG_AW-1:0]  regAddr;
        word_t              regData;
        logic               memWe;
        logic [`MEM_AW-1:0] memAddr;
    } retire_t;

endpackage

// File: hw/isaPkg.sv
package isaPkg;

    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0]
    {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_e;

    typedef struct packed
    {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt; // no shifts, ignored
        funct_e     funct;
    } rFormat_t;

    typedef struct packed
    {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat_t;

    typedef struct packed
    {
        opcode_e     op;
        logic [25:0] target;
    } jFormat_t;

    // one fetched word, viewed in whichever format the opcode implies
    typedef union packed
    {
        rFormat_t    r;
        iFormat_t    i;
        jFormat_t    j;
        logic [31:0] raw;
    } instr_u;

endpackage

// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address word width
`define XLEN 32

// architectural registers
`define REG_COUNT 32

// memory depth in words, and the word address width to match
`define MEM_WORDS 256
`define MEM_AW 8

`endif
